// ==== tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

	// ======================================================================
	// address and array geometry
	// ======================================================================
	localparam int VADDR_W    = 32;
	localparam int PADDR_W    = 32;
	// 16 kB pages
	localparam int PAGE_OFS_W = 14;
	// set index is vadr[19:14]
	localparam int SET_W      = 6;
	localparam int TLB_SETS   = 64;
	// tag is vadr[31:20]
	localparam int TAG_W      = 12;
	// last way is reserved for the rom mapping
	localparam int TLB_WAYS   = 4;
	localparam int WAY_W      = 2;
	localparam int ASID_W     = 8;
	localparam int PPN_W      = 18;
	localparam int RWX_W      = 3;

	// ======================================================================
	// entry layout, msb first: asid, g, m, rwx, tag, ppn
	// ======================================================================
	localparam int ENTRY_W      = ASID_W + 1 + 1 + RWX_W + TAG_W + PPN_W;
	localparam int ENT_PPN_LSB  = 0;
	localparam int ENT_TAG_LSB  = ENT_PPN_LSB + PPN_W;
	localparam int ENT_RWX_LSB  = ENT_TAG_LSB + TAG_W;
	localparam int ENT_M_BIT    = ENT_RWX_LSB + RWX_W;
	localparam int ENT_G_BIT    = ENT_M_BIT + 1;
	localparam int ENT_ASID_LSB = ENT_G_BIT + 1;

	// ======================================================================
	// rom region, top 256 kB identity mapped
	// ======================================================================
	localparam logic [TAG_W-1:0] ROM_TAG      = '1;
	localparam logic [SET_W-1:0] ROM_SET_BASE = 6'd48;
	localparam int               ROM_PAGES    = 16;
	localparam int               ROM_CNT_W    = $clog2(ROM_PAGES);
	localparam logic [PPN_W-1:0] ROM_PPN_BASE = 18'h3FFF0;

	// maintenance address: set in [7:2], way in [1:0]
	localparam int TLBADR_W = 8;

endpackage

`default_nettype wire

// ==== tlb_way_ram.sv ====
`default_nettype none

module tlb_way_ram (
	input  wire                         clk_g,
	// maintenance port
	input  wire                         a_en_i,
	input  wire                         a_we_i,
	input  wire [tlb_pkg::SET_W-1:0]    a_addr_i,
	input  wire [tlb_pkg::ENTRY_W-1:0]  a_din_i,
	output logic [tlb_pkg::ENTRY_W-1:0] a_dout_o,
	// translation port
	input  wire                         b_en_i,
	input  wire                         b_we_i,
	input  wire [tlb_pkg::SET_W-1:0]    b_addr_i,
	input  wire [tlb_pkg::ENTRY_W-1:0]  b_din_i,
	output logic [tlb_pkg::ENTRY_W-1:0] b_dout_o
);
	import tlb_pkg::*;

	// one entry per set
	logic [ENTRY_W-1:0] mem [TLB_SETS];

	// port a, a write takes priority over a read
	always_ff @(posedge clk_g) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_din_i;
		end else if (a_en_i) begin
			a_dout_o <= mem[a_addr_i];
		end
	end

	// port b, output register holds the last value read
	always_ff @(posedge clk_g) begin
		if (b_we_i) begin
			mem[b_addr_i] <= b_din_i;
		end else if (b_en_i) begin
			b_dout_o <= mem[b_addr_i];
		end
	end

endmodule

`default_nettype wire

// ==== tlb_fill_ctrl.sv ====
`default_nettype none

module tlb_fill_ctrl (
	input  wire                                            clk_g,
	input  wire                                            rst_i,
	// software maintenance interface
	input  wire                                            tlben_i,
	input  wire                                            wrtlb_i,
	input  wire                                            random_i,
	input  wire [tlb_pkg::TLBADR_W-1:0]                    tlbadr_i,
	input  wire [tlb_pkg::ENTRY_W-1:0]                     tlbdat_i,
	output logic [tlb_pkg::ENTRY_W-1:0]                    tlbdat_o,
	output logic                                           rdy_o,
	// ram port a
	output logic                                           a_en_o,
	output logic [tlb_pkg::TLB_WAYS-1:0]                   a_we_o,
	output logic [tlb_pkg::SET_W-1:0]                      a_addr_o,
	output logic [tlb_pkg::ENTRY_W-1:0]                    a_din_o,
	input  wire [tlb_pkg::TLB_WAYS*tlb_pkg::ENTRY_W-1:0]  a_dout_i
);
	import tlb_pkg::*;

	typedef enum logic {
		ST_FILL,
		ST_RUN
	} fill_state_t;

	fill_state_t          state;
	logic [ROM_CNT_W-1:0] fill_cnt;
	logic [WAY_W-1:0]     rand_way;
	logic [WAY_W-1:0]     rd_way;
	logic [TLB_WAYS-1:0]  wr_sel;
	logic [ENTRY_W-1:0]   fill_ent;

	// rom entry for the current fill page
	// asid 0, global, not modified, full rwx, identity mapped
	always_comb begin
		fill_ent = '0;
		fill_ent[ENT_G_BIT] = 1'b1;
		fill_ent[ENT_RWX_LSB +: RWX_W] = '1;
		fill_ent[ENT_TAG_LSB +: TAG_W] = ROM_TAG;
		fill_ent[ENT_PPN_LSB +: PPN_W] = ROM_PPN_BASE + PPN_W'(fill_cnt);
	end

	// way decode for a software write
	always_comb begin
		wr_sel = '0;
		wr_sel[random_i ? rand_way : tlbadr_i[WAY_W-1:0]] = 1'b1;
	end

	// ======================================================================
	// control: fill sequence, software strobes, random way
	// ======================================================================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			state    <= ST_FILL;
			fill_cnt <= '0;
			rdy_o    <= 1'b0;
			a_en_o   <= 1'b0;
			a_we_o   <= '0;
			rd_way   <= '0;
			rand_way <= '0;
		end else begin
			a_en_o <= 1'b0;
			a_we_o <= '0;
			// ready one cycle after run, so the last fill write has landed
			rdy_o  <= (state == ST_RUN);
			// random way walks 0,1,2 and never touches the rom way
			if (!wrtlb_i) begin
				if (rand_way == WAY_W'(TLB_WAYS - 2)) begin
					rand_way <= '0;
				end else begin
					rand_way <= rand_way + 1'b1;
				end
			end
			case (state)
				ST_FILL: begin
					a_we_o[TLB_WAYS-1] <= 1'b1;
					fill_cnt <= fill_cnt + 1'b1;
					if (&fill_cnt) begin
						state <= ST_RUN;
					end
				end
				ST_RUN: begin
					// strobes before ready are dropped
					if (rdy_o && wrtlb_i) begin
						a_we_o <= wr_sel;
					end else if (rdy_o && tlben_i) begin
						a_en_o <= 1'b1;
						rd_way <= tlbadr_i[WAY_W-1:0];
					end
				end
				default: state <= ST_RUN;
			endcase
		end
	end

	// address and data staged alongside the strobes
	always_ff @(posedge clk_g) begin
		if (state == ST_FILL) begin
			a_addr_o <= ROM_SET_BASE + SET_W'(fill_cnt);
			a_din_o  <= fill_ent;
		end else begin
			a_addr_o <= tlbadr_i[TLBADR_W-1 -: SET_W];
			a_din_o  <= tlbdat_i;
		end
	end

	// read data from the way named by the last read
	assign tlbdat_o = a_dout_i[rd_way*ENTRY_W +: ENTRY_W];

endmodule

`default_nettype wire

// ==== tlb_lookup.sv ====
`default_nettype none

module tlb_lookup (
	input  wire                                            clk_g,
	input  wire                                            rst_i,
	input  wire                                            acc_i,
	input  wire [tlb_pkg::VADDR_W-1:0]                     vadr_i,
	input  wire [tlb_pkg::ASID_W-1:0]                      asid_i,
	input  wire                                            we_i,
	input  wire [tlb_pkg::TLB_WAYS*tlb_pkg::ENTRY_W-1:0]  b_dout_i,
	// translation result
	output logic                                           result_valid_o,
	output logic [tlb_pkg::PADDR_W-1:0]                    padr_o,
	output logic [3:0]                                     acr_o,
	output logic                                           tlbmiss_o,
	output logic [tlb_pkg::WAY_W-1:0]                      hit_way_o,
	// hit information for the dirty update
	output logic                                           hit_valid_o,
	output logic [tlb_pkg::SET_W-1:0]                      hit_set_o,
	output logic [tlb_pkg::ENTRY_W-1:0]                    hit_entry_o,
	output logic                                           hit_store_o
);
	import tlb_pkg::*;

	// stage 1, request held while the rams read
	logic               v1;
	logic [VADDR_W-1:0] va1;
	logic [ASID_W-1:0]  asid1;
	logic               we1;

	// stage 2 compare
	logic               hit;
	logic [WAY_W-1:0]   hit_w;
	logic [ENTRY_W-1:0] hit_e;
	logic               rom_page;

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			v1 <= 1'b0;
		end else begin
			v1 <= acc_i;
		end
	end

	always_ff @(posedge clk_g) begin
		if (acc_i) begin
			va1   <= vadr_i;
			asid1 <= asid_i;
			we1   <= we_i;
		end
	end

	// ======================================================================
	// parallel tag compare, highest way wins
	// ======================================================================
	always_comb begin
		logic [ENTRY_W-1:0] e;
		hit   = 1'b0;
		hit_w = '0;
		hit_e = '0;
		for (int w = 0; w < TLB_WAYS; w++) begin
			e = b_dout_i[w*ENTRY_W +: ENTRY_W];
			// tag, valid permission, and asid or global
			if (e[ENT_TAG_LSB +: TAG_W] == va1[VADDR_W-1 -: TAG_W] &&
			    |e[ENT_RWX_LSB +: RWX_W] &&
			    (e[ENT_ASID_LSB +: ASID_W] == asid1 || e[ENT_G_BIT])) begin
				hit   = 1'b1;
				hit_w = WAY_W'(w);
				hit_e = e;
			end
		end
	end

	// rom pages sit at the top of the physical map
	assign rom_page = (hit_e[ENT_PPN_LSB +: PPN_W] >= ROM_PPN_BASE);

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			result_valid_o <= 1'b0;
			tlbmiss_o      <= 1'b0;
			acr_o          <= '0;
			hit_way_o      <= '0;
			hit_valid_o    <= 1'b0;
			hit_store_o    <= 1'b0;
		end else begin
			result_valid_o <= v1;
			// write back only for a store that hits
			hit_valid_o    <= v1 & hit & we1;
			if (v1) begin
				tlbmiss_o   <= ~hit;
				hit_store_o <= we1;
				// no access on a miss
				acr_o <= hit ? {rom_page, hit_e[ENT_RWX_LSB +: RWX_W]} : 4'h0;
				if (hit) begin
					hit_way_o <= hit_w;
				end
			end
		end
	end

	// result payload, padr keeps its old value on a miss
	always_ff @(posedge clk_g) begin
		if (v1) begin
			hit_set_o <= va1[PAGE_OFS_W +: SET_W];
			if (hit) begin
				padr_o      <= {hit_e[ENT_PPN_LSB +: PPN_W], va1[PAGE_OFS_W-1:0]};
				hit_entry_o <= hit_e;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tlb_dirty_update.sv ====
`default_nettype none

module tlb_dirty_update (
	input  wire                         clk_g,
	input  wire                         rst_i,
	input  wire                         xlaten_i,
	input  wire [tlb_pkg::VADDR_W-1:0]  vadr_i,
	// hit from the lookup
	input  wire                         hit_valid_i,
	input  wire                         hit_store_i,
	input  wire [tlb_pkg::SET_W-1:0]    hit_set_i,
	input  wire [tlb_pkg::WAY_W-1:0]    hit_way_i,
	input  wire [tlb_pkg::ENTRY_W-1:0]  hit_entry_i,
	// ram port b
	output logic                        xlat_busy_o,
	output logic                        b_en_o,
	output logic [tlb_pkg::SET_W-1:0]   b_addr_o,
	output logic [tlb_pkg::TLB_WAYS-1:0] b_we_o,
	output logic [tlb_pkg::ENTRY_W-1:0] b_din_o
);
	import tlb_pkg::*;

	logic               wb_pend;
	logic [SET_W-1:0]   wb_set;
	logic [WAY_W-1:0]   wb_way;
	logic [ENTRY_W-1:0] wb_ent;

	// one write-back cycle follows each store hit
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			wb_pend <= 1'b0;
		end else begin
			wb_pend <= hit_valid_i & hit_store_i;
		end
	end

	// capture the hit entry with the modified bit set
	always_ff @(posedge clk_g) begin
		if (hit_valid_i) begin
			wb_set <= hit_set_i;
			wb_way <= hit_way_i;
			wb_ent <= hit_entry_i | (ENTRY_W'(1) << ENT_M_BIT);
		end
	end

	// ======================================================================
	// port b mux, write-back steals the port from translation
	// ======================================================================
	assign xlat_busy_o = wb_pend;
	assign b_en_o      = xlaten_i & ~wb_pend;
	assign b_addr_o    = wb_pend ? wb_set : vadr_i[PAGE_OFS_W +: SET_W];
	assign b_din_o     = wb_ent;

	always_comb begin
		b_we_o = '0;
		// only the way that hit is written
		if (wb_pend) begin
			b_we_o[wb_way] = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== tlb_top.sv ====
`default_nettype none

module tlb_top (
	input  wire                         clk_g,
	input  wire                         rst_i,
	// maintenance
	input  wire                         tlben_i,
	input  wire                         wrtlb_i,
	input  wire                         random_i,
	input  wire [tlb_pkg::TLBADR_W-1:0] tlbadr_i,
	input  wire [tlb_pkg::ENTRY_W-1:0]  tlbdat_i,
	output logic [tlb_pkg::ENTRY_W-1:0] tlbdat_o,
	output logic                        rdy_o,
	// translation
	input  wire                         xlaten_i,
	input  wire [tlb_pkg::VADDR_W-1:0]  vadr_i,
	input  wire [tlb_pkg::ASID_W-1:0]   asid_i,
	input  wire                         we_i,
	output logic                        xlat_busy_o,
	output logic                        result_valid_o,
	output logic [tlb_pkg::PADDR_W-1:0] padr_o,
	output logic [3:0]                  acr_o,
	output logic                        tlbmiss_o,
	output logic [tlb_pkg::WAY_W-1:0]   hit_way_o
);
	import tlb_pkg::*;

	// port a, shared address and data, per-way write enable
	logic                         a_en;
	logic [TLB_WAYS-1:0]          a_we;
	logic [SET_W-1:0]             a_addr;
	logic [ENTRY_W-1:0]           a_din;
	logic [TLB_WAYS*ENTRY_W-1:0]  a_dout;
	// port b
	logic                         b_en;
	logic [TLB_WAYS-1:0]          b_we;
	logic [SET_W-1:0]             b_addr;
	logic [ENTRY_W-1:0]           b_din;
	logic [TLB_WAYS*ENTRY_W-1:0]  b_dout;
	// lookup to dirty update
	logic                         hit_valid;
	logic [SET_W-1:0]             hit_set;
	logic [ENTRY_W-1:0]           hit_entry;
	logic                         hit_store;

	tlb_fill_ctrl u_fill (
		.clk_g(clk_g), .rst_i(rst_i),
		.tlben_i(tlben_i), .wrtlb_i(wrtlb_i), .random_i(random_i),
		.tlbadr_i(tlbadr_i), .tlbdat_i(tlbdat_i), .tlbdat_o(tlbdat_o), .rdy_o(rdy_o),
		.a_en_o(a_en), .a_we_o(a_we), .a_addr_o(a_addr), .a_din_o(a_din),
		.a_dout_i(a_dout)
	);

	// b_en doubles as the stage-0 accept strobe
	tlb_lookup u_lookup (
		.clk_g(clk_g), .rst_i(rst_i),
		.acc_i(b_en), .vadr_i(vadr_i), .asid_i(asid_i), .we_i(we_i), .b_dout_i(b_dout),
		.result_valid_o(result_valid_o), .padr_o(padr_o), .acr_o(acr_o),
		.tlbmiss_o(tlbmiss_o), .hit_way_o(hit_way_o),
		.hit_valid_o(hit_valid), .hit_set_o(hit_set), .hit_entry_o(hit_entry),
		.hit_store_o(hit_store)
	);

	tlb_dirty_update u_dirty (
		.clk_g(clk_g), .rst_i(rst_i),
		.xlaten_i(xlaten_i), .vadr_i(vadr_i),
		.hit_valid_i(hit_valid), .hit_store_i(hit_store), .hit_set_i(hit_set),
		.hit_way_i(hit_way_o), .hit_entry_i(hit_entry),
		.xlat_busy_o(xlat_busy_o), .b_en_o(b_en), .b_addr_o(b_addr),
		.b_we_o(b_we), .b_din_o(b_din)
	);

	// ======================================================================
	// one dual-port ram per way
	// ======================================================================
	for (genvar w = 0; w < TLB_WAYS; w++) begin : g_way
		tlb_way_ram u_ram (
			.clk_g(clk_g),
			.a_en_i(a_en), .a_we_i(a_we[w]), .a_addr_i(a_addr), .a_din_i(a_din),
			.a_dout_o(a_dout[w*ENTRY_W +: ENTRY_W]),
			.b_en_i(b_en), .b_we_i(b_we[w]), .b_addr_i(b_addr), .b_din_i(b_din),
			.b_dout_o(b_dout[w*ENTRY_W +: ENTRY_W])
		);
	end

endmodule

`default_nettype wire

// ==== tb_tlb.sv ====
`default_nettype none

module tb_tlb;
	import tlb_pkg::*;

	// row operations
	localparam logic [2:0] OP_WR   = 3'd0;
	localparam logic [2:0] OP_WRR  = 3'd1;
	localparam logic [2:0] OP_RD   = 3'd2;
	localparam logic [2:0] OP_LK   = 3'd3;
	localparam logic [2:0] OP_ST   = 3'd4;
	localparam logic [2:0] OP_PIPE = 3'd5;
	localparam int         MAX_ROWS = 64;

	logic                 clk_g;
	logic                 rst_i;
	logic                 tlben_i;
	logic                 wrtlb_i;
	logic                 random_i;
	logic [TLBADR_W-1:0]  tlbadr_i;
	logic [ENTRY_W-1:0]   tlbdat_i;
	logic [ENTRY_W-1:0]   tlbdat_o;
	logic                 rdy_o;
	logic                 xlaten_i;
	logic [VADDR_W-1:0]   vadr_i;
	logic [ASID_W-1:0]    asid_i;
	logic                 we_i;
	logic                 xlat_busy_o;
	logic                 result_valid_o;
	logic [PADDR_W-1:0]   padr_o;
	logic [3:0]           acr_o;
	logic                 tlbmiss_o;
	logic [WAY_W-1:0]     hit_way_o;

	// stimulus table with t_data as write data or expected read data
	logic [2:0]           t_op   [MAX_ROWS];
	logic [31:0]          t_addr [MAX_ROWS];
	logic [ASID_W-1:0]    t_asid [MAX_ROWS];
	logic [ENTRY_W-1:0]   t_data [MAX_ROWS];
	logic                 t_miss [MAX_ROWS];
	logic [PADDR_W-1:0]   t_padr [MAX_ROWS];
	logic [3:0]           t_acr  [MAX_ROWS];
	// expected way where -1 means any way below the rom way
	int                   t_way  [MAX_ROWS];
	int                   n_rows = 0;
	int                   seed = 29766;
	int                   cycle_cnt = 0;
	int                   cycle_limit = 1000;

	tlb_top dut0 (.*);

	initial begin
		clk_g = 1'b0;
		forever #50 clk_g = ~clk_g;
	end

	// run limit is set once the table is built
	always @(posedge clk_g) begin
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Test failures found");
			$fatal(1, "simulation stopped by the cycle limit");
		end else begin
			cycle_cnt <= cycle_cnt + 1;
		end
	end

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("ERROR at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// ======================================================================
	// entry packing and table building
	// ======================================================================
	function automatic logic [ENTRY_W-1:0] make_entry(input logic [7:0] asid, input logic g,
		input logic m, input logic [2:0] rwx, input logic [11:0] tag, input logic [17:0] ppn);
		logic [ENTRY_W-1:0] e;
		e = '0;
		e[ENT_ASID_LSB +: ASID_W] = asid;
		e[ENT_G_BIT]              = g;
		e[ENT_M_BIT]              = m;
		e[ENT_RWX_LSB +: 3]       = rwx;
		e[ENT_TAG_LSB +: TAG_W]   = tag;
		e[ENT_PPN_LSB +: PPN_W]   = ppn;
		return e;
	endfunction

	function automatic logic [31:0] vaddr(input logic [11:0] tag, input logic [5:0] set,
		input logic [13:0] ofs);
		return {tag, set, ofs};
	endfunction

	function automatic logic [13:0] rand_ofs();
		logic [31:0] r;
		r = $random(seed);
		return r[13:0];
	endfunction

	function automatic logic [7:0] rand_asid();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic add_row(input logic [2:0] op, input logic [31:0] addr, input logic [7:0] asid,
		input logic [ENTRY_W-1:0] data, input logic miss, input logic [31:0] padr,
		input logic [3:0] acr, input int way);
		t_op[n_rows]   = op;
		t_addr[n_rows] = addr;
		t_asid[n_rows] = asid;
		t_data[n_rows] = data;
		t_miss[n_rows] = miss;
		t_padr[n_rows] = padr;
		t_acr[n_rows]  = acr;
		t_way[n_rows]  = way;
		n_rows++;
	endtask

	task automatic add_write(input logic [2:0] op, input logic [5:0] set, input int way,
		input logic [ENTRY_W-1:0] e);
		add_row(op, {24'd0, set, way[1:0]}, 8'd0, e, 1'b0, 32'd0, 4'h0, 0);
	endtask

	task automatic add_read(input logic [5:0] set, input int way, input logic [ENTRY_W-1:0] e);
		add_row(OP_RD, {24'd0, set, way[1:0]}, 8'd0, e, 1'b0, 32'd0, 4'h0, 0);
	endtask

	// expected hit with the ppn joined to the offset
	task automatic add_hit(input logic [2:0] op, input logic [31:0] va, input logic [7:0] asid,
		input logic [17:0] ppn, input logic [3:0] acr, input int way);
		add_row(op, va, asid, '0, 1'b0, {ppn, va[13:0]}, acr, way);
	endtask

	task automatic add_miss(input logic [2:0] op, input logic [31:0] va, input logic [7:0] asid);
		add_row(op, va, asid, '0, 1'b1, 32'd0, 4'h0, -1);
	endtask

	task automatic build_table();
		logic [ENTRY_W-1:0] e1, e2, e3, e4, e5, e6;
		logic [7:0]         a1, a2, a4, a5, a6;
		logic [31:0]        va;
		a1 = rand_asid();
		a2 = rand_asid();
		a4 = rand_asid();
		a5 = rand_asid();
		a6 = rand_asid();
		e1 = make_entry(a1, 1'b0, 1'b0, 3'b101, 12'h123, 18'h01234);
		e2 = make_entry(a2, 1'b0, 1'b0, 3'b011, 12'h456, 18'h2ABCD);
		e3 = make_entry(8'h44, 1'b1, 1'b0, 3'b110, 12'h789, 18'h00777);
		e4 = make_entry(a4, 1'b0, 1'b0, 3'b000, 12'h0AB, 18'h00111);
		e5 = make_entry(a5, 1'b0, 1'b0, 3'b111, 12'h3C3, 18'h00ABC);
		e6 = make_entry(a6, 1'b0, 1'b0, 3'b100, 12'h5A5, 18'h3FFF8);
		// rom pages are identity mapped in way 3 for any asid
		for (int k = 0; k < ROM_PAGES; k++) begin
			va = 32'hFFFC0000 + (32'(k) << 14) + {18'd0, rand_ofs()};
			add_hit(OP_LK, va, rand_asid(), va[31:14], 4'hF, 3);
		end
		// explicit ways are read back and then hit
		add_write(OP_WR, 6'd5, 0, e1);
		add_read(6'd5, 0, e1);
		add_hit(OP_LK, vaddr(12'h123, 6'd5, rand_ofs()), a1, 18'h01234, 4'h5, 0);
		add_write(OP_WR, 6'd9, 1, e2);
		add_read(6'd9, 1, e2);
		add_hit(OP_LK, vaddr(12'h456, 6'd9, rand_ofs()), a2, 18'h2ABCD, 4'h3, 1);
		add_write(OP_WR, 6'd12, 2, e3);
		add_read(6'd12, 2, e3);
		add_hit(OP_LK, vaddr(12'h789, 6'd12, rand_ofs()), 8'h44, 18'h00777, 4'h6, 2);
		// wrong asid, no permission, unknown tag, then global with a foreign asid
		add_miss(OP_LK, vaddr(12'h123, 6'd5, rand_ofs()), a1 ^ 8'h01);
		add_write(OP_WR, 6'd20, 1, e4);
		add_miss(OP_LK, vaddr(12'h0AB, 6'd20, rand_ofs()), a4);
		add_miss(OP_LK, vaddr(12'h9FE, 6'd30, rand_ofs()), a1);
		add_hit(OP_LK, vaddr(12'h789, 6'd12, rand_ofs()), 8'h44 ^ 8'h5A, 18'h00777, 4'h6, 2);
		// a store hit sets m and the next lookup meets the write-back cycle
		add_hit(OP_ST, vaddr(12'h456, 6'd9, rand_ofs()), a2, 18'h2ABCD, 4'h3, 1);
		add_hit(OP_LK, vaddr(12'h456, 6'd9, rand_ofs()), a2, 18'h2ABCD, 4'h3, 1);
		add_read(6'd9, 1, make_entry(a2, 1'b0, 1'b1, 3'b011, 12'h456, 18'h2ABCD));
		add_read(6'd5, 0, e1);
		// random way writes
		add_write(OP_WRR, 6'd40, 0, e5);
		add_hit(OP_LK, vaddr(12'h3C3, 6'd40, rand_ofs()), a5, 18'h00ABC, 4'h7, -1);
		add_write(OP_WRR, 6'd41, 0, e6);
		// ppn inside the rom range so the access code carries the rom flag
		add_hit(OP_LK, vaddr(12'h5A5, 6'd41, rand_ofs()), a6, 18'h3FFF8, 4'hC, -1);
		// back-to-back burst
		add_hit(OP_PIPE, vaddr(12'h123, 6'd5, rand_ofs()), a1, 18'h01234, 4'h5, 0);
		add_hit(OP_PIPE, vaddr(12'h789, 6'd12, rand_ofs()), 8'h44, 18'h00777, 4'h6, 2);
		add_hit(OP_PIPE, 32'hFFFCC000 + {18'd0, rand_ofs()}, rand_asid(), 18'h3FFF3, 4'hF, 3);
		add_hit(OP_PIPE, vaddr(12'h456, 6'd9, rand_ofs()), a2, 18'h2ABCD, 4'h3, 1);
		add_miss(OP_PIPE, vaddr(12'h9FE, 6'd30, rand_ofs()), a1);
	endtask

	// ======================================================================
	// row execution with every input change on the falling edge
	// ======================================================================
	task automatic compare_result(input int r);
		check(64'(tlbmiss_o), 64'(t_miss[r]), $sformatf("row %0d miss flag", r));
		check(64'(acr_o), 64'(t_acr[r]), $sformatf("row %0d access code", r));
		if (!t_miss[r]) begin
			check(64'(padr_o), 64'(t_padr[r]), $sformatf("row %0d physical address", r));
			if (t_way[r] >= 0) begin
				check(64'(hit_way_o), 64'(t_way[r]), $sformatf("row %0d hit way", r));
			end else begin
				check(64'(hit_way_o < 2'd3), 64'd1, $sformatf("row %0d random way", r));
			end
		end
	endtask

	task automatic do_write(input int r);
		tlbadr_i = t_addr[r][7:0];
		tlbdat_i = t_data[r];
		random_i = (t_op[r] == OP_WRR);
		wrtlb_i  = 1'b1;
		@(negedge clk_g);
		wrtlb_i  = 1'b0;
		random_i = 1'b0;
		@(negedge clk_g);
	endtask

	task automatic do_read(input int r);
		tlbadr_i = t_addr[r][7:0];
		tlben_i  = 1'b1;
		@(negedge clk_g);
		tlben_i  = 1'b0;
		@(negedge clk_g);
		check(64'(tlbdat_o), 64'(t_data[r]), $sformatf("row %0d read data", r));
		@(negedge clk_g);
	endtask

	task automatic do_lookup(input int r);
		vadr_i   = t_addr[r];
		asid_i   = t_asid[r];
		we_i     = (t_op[r] == OP_ST);
		xlaten_i = 1'b1;
		// held while the port is taken by a write-back
		while (xlat_busy_o) @(negedge clk_g);
		@(negedge clk_g);
		xlaten_i = 1'b0;
		we_i     = 1'b0;
		while (!result_valid_o) @(negedge clk_g);
		compare_result(r);
		@(negedge clk_g);
		// a store that hits takes the port for the cycle after its result
		check(64'(xlat_busy_o), 64'(t_op[r] == OP_ST && !t_miss[r]),
			$sformatf("row %0d busy after result", r));
	endtask

	task automatic run_burst(input int first, input int last);
		int issued;
		int got;
		issued = first;
		got    = first;
		while (got <= last) begin
			// sample the result before driving the next request
			if (result_valid_o) begin
				compare_result(got);
				got++;
			end
			if (issued <= last) begin
				vadr_i   = t_addr[issued];
				asid_i   = t_asid[issued];
				xlaten_i = 1'b1;
				issued++;
			end else begin
				xlaten_i = 1'b0;
			end
			@(negedge clk_g);
		end
		@(negedge clk_g);
	endtask

	initial begin
		int i;
		int j;
		rst_i    = 1'b1;
		tlben_i  = 1'b0;
		wrtlb_i  = 1'b0;
		random_i = 1'b0;
		tlbadr_i = '0;
		tlbdat_i = '0;
		xlaten_i = 1'b0;
		vadr_i   = '0;
		asid_i   = '0;
		we_i     = 1'b0;
		build_table();
		// reset plus fill and then a handful of cycles per row
		cycle_limit = 20 + 8 * n_rows;
		repeat (3) @(negedge clk_g);
		rst_i = 1'b0;
		check(64'(rdy_o), 64'd0, "rdy_o after reset");
		while (!rdy_o) @(negedge clk_g);
		i = 0;
		while (i < n_rows) begin
			case (t_op[i])
				OP_WR, OP_WRR: do_write(i);
				OP_RD: do_read(i);
				OP_LK, OP_ST: do_lookup(i);
				default: begin
					j = i;
					while (j + 1 < n_rows && t_op[j+1] == OP_PIPE) j++;
					run_burst(i, j);
					i = j;
				end
			endcase
			i++;
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
tlb_pkg.sv
tlb_way_ram.sv
tlb_fill_ctrl.sv
tlb_lookup.sv
tlb_dirty_update.sv
tlb_top.sv
tb_tlb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the tlb testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --top-module tb_tlb -f compile.f \
	--Mdir "$BUILD_DIR" -o sim_tlb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Build failed"
	exit 1
fi

"./$BUILD_DIR/sim_tlb" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Test failures found" "$SIM_LOG"; then
	echo "Simulation reported failures"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi
echo "Simulation passed"
exit 0
